//--- hdl/zx_pkg.sv
package zx_pkg;

	typedef logic [7:0] byte_t;

	// identity of a decoded Z80 I/O port
	typedef enum logic [2:0]
	{
		PORT_NONE,
		PORT_FE,
		PORT_7FFD,
		PORT_EFF7,
		PORT_AY_REG,
		PORT_AY_DATA
	} port_sel_t;

	// EFF7 bit 2 picks the memory mode
	typedef enum logic
	{
		MODE_1024 = 1'b0,
		MODE_128  = 1'b1
	} mem_mode_t;

	localparam int RAM_PAGE_W = 6;
	localparam int ROM_PAGE_W = 5;

	// high address byte of the DOS entry points
	localparam byte_t DOS_ENTRY_HI = 8'h3D;

	// partial decode for FE and 7FFD, full decode for the rest
	function automatic port_sel_t port_decode(input logic [15:0] addr);
		if (!addr[0])
			return PORT_FE;
		else if (!addr[15] && !addr[1])
			return PORT_7FFD;
		else if (addr == 16'hEFF7)
			return PORT_EFF7;
		else if (addr == 16'hFFFD)
			return PORT_AY_REG;
		else if (addr == 16'hBFFD)
			return PORT_AY_DATA;
		else
			return PORT_NONE;
	endfunction

endpackage

//--- hdl/zx_bus_sync.sv
`timescale 1ns/100ps

module zx_bus_sync import zx_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,

	input  logic [15:0] a,
	input  byte_t       d_in,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,

	output logic        io_wr_stb,
	output logic        m1_stb,
	output port_sel_t   wr_port,
	output byte_t       wr_data,
	output byte_t       m1_addr_hi
);

	// bit positions in the strobe vector
	localparam int S_IORQ = 4;
	localparam int S_MREQ = 3;
	localparam int S_RD   = 2;
	localparam int S_WR   = 1;
	localparam int S_M1   = 0;

	logic [4:0] strb_meta;
	logic [4:0] strb_sync;
	logic       io_wr_lvl;
	logic       m1_rd_lvl;
	logic       io_wr_prev;
	logic       m1_rd_prev;

	////////////////////
	// two-flop synchronizers, strobes idle high
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			strb_meta <= '1;
			strb_sync <= '1;
		end
		else
		begin
			strb_meta <= {iorq_n, mreq_n, rd_n, wr_n, m1_n};
			strb_sync <= strb_meta;
		end
	end

	assign io_wr_lvl = !strb_sync[S_IORQ] && !strb_sync[S_WR];
	assign m1_rd_lvl = !strb_sync[S_M1] && !strb_sync[S_MREQ] && !strb_sync[S_RD];

	////////////////////
	// rising edge of the combined strobes
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_prev <= 1'b0;
			m1_rd_prev <= 1'b0;
			io_wr_stb  <= 1'b0;
			m1_stb     <= 1'b0;
		end
		else
		begin
			io_wr_prev <= io_wr_lvl;
			m1_rd_prev <= m1_rd_lvl;
			io_wr_stb  <= io_wr_lvl && !io_wr_prev;
			m1_stb     <= m1_rd_lvl && !m1_rd_prev;
		end
	end

	// bus is still held, so raw pins are stable here
	always_ff @(posedge fclk)
	begin
		if (io_wr_lvl && !io_wr_prev)
		begin
			wr_port <= port_decode(a);
			wr_data <= d_in;
		end
		if (m1_rd_lvl && !m1_rd_prev)
			m1_addr_hi <= a[15:8];
	end

	// an I/O write and an opcode fetch never overlap on the Z80 bus
	a_no_dual_event: assert property (@(posedge fclk) disable iff (!rst_n)
		!(io_wr_stb && m1_stb));

endmodule

//--- hdl/zx_port_regs.sv
`timescale 1ns/100ps

module zx_port_regs import zx_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,

	input  logic        io_wr_stb,
	input  port_sel_t   wr_port,
	input  byte_t       wr_data,

	input  logic [15:0] a,
	input  logic        ear_in,
	input  logic        iorqge1,
	input  logic        iorqge2,

	output logic [2:0]  border,
	output byte_t       p7ffd,
	output byte_t       peff7,
	output mem_mode_t   mem_mode,
	output byte_t       rd_data,
	output logic        port_unowned
);

	port_sel_t rd_port;
	logic      p7ffd_lock;

	assign mem_mode = mem_mode_t'(peff7[2]);

	// 7FFD bit 5 freezes paging, 128K mode only
	assign p7ffd_lock = (mem_mode == MODE_128) && p7ffd[5];

	////////////////////
	// register writes
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 3'd0;
			p7ffd  <= 8'h00;
			peff7  <= 8'h00;
		end
		else if (io_wr_stb)
		begin
			case (wr_port)
				PORT_FE:
					border <= wr_data[2:0];
				PORT_7FFD:
				begin
					if (!p7ffd_lock)
						p7ffd <= wr_data;
				end
				PORT_EFF7:
					peff7 <= wr_data;
				default:
				begin
				end
			endcase
		end
	end

	////////////////////
	// read side, straight from the live address
	assign rd_port = port_decode(a);

	always_comb
	begin
		case (rd_port)
			PORT_FE:   rd_data = {1'b1, ear_in, 6'h3F};
			PORT_7FFD: rd_data = p7ffd;
			PORT_EFF7: rd_data = peff7;
			default:   rd_data = 8'hFF;
		endcase
	end

	// nobody inside or on the expansion bus answers
	assign port_unowned = (rd_port == PORT_NONE) && !iorqge1 && !iorqge2;

endmodule

//--- hdl/zx_pager.sv
`timescale 1ns/100ps

module zx_pager import zx_pkg::*;
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic [15:14]          a,
	input  logic                  mreq_n,
	input  logic                  m1_stb,
	input  byte_t                 m1_addr_hi,

	input  byte_t                 p7ffd,
	input  byte_t                 peff7,
	input  mem_mode_t             mem_mode,

	output logic [RAM_PAGE_W-1:0] ram_page,
	output logic                  rom_sel,
	output logic [ROM_PAGE_W-1:0] rom_page
);

	logic                  dos;
	logic                  win0_rom;
	logic                  fetch_ok;
	logic [RAM_PAGE_W-1:0] page_nxt;

	// EFF7 bit 3 puts RAM 0 under the ROM window
	assign win0_rom = !peff7[3];

	////////////////////
	// window to page map
	always_comb
	begin
		case (a)
			2'd0:    page_nxt = '0;
			2'd1:    page_nxt = RAM_PAGE_W'(5);
			2'd2:    page_nxt = RAM_PAGE_W'(2);
			default:
			begin
				if (mem_mode == MODE_128)
					page_nxt = RAM_PAGE_W'(p7ffd[2:0]);
				else
					page_nxt = RAM_PAGE_W'({p7ffd[5], p7ffd[7:6], p7ffd[2:0]});
			end
		endcase
	end

	////////////////////
	// DOS flag from opcode fetches
	// fetch still in progress when the late event arrives
	assign fetch_ok = m1_stb && !mreq_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (fetch_ok)
		begin
			if (m1_addr_hi == DOS_ENTRY_HI && win0_rom && p7ffd[4])
				dos <= 1'b1;
			else if (m1_addr_hi[7:6] != 2'b00)
				dos <= 1'b0;
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ram_page <= '0;
			rom_sel  <= 1'b0;
			rom_page <= {{(ROM_PAGE_W-2){1'b0}}, 2'b10};
		end
		else
		begin
			ram_page <= page_nxt;
			rom_sel  <= (a == 2'd0) && win0_rom;
			// bit 1 low selects the DOS ROM
			rom_page <= {{(ROM_PAGE_W-2){1'b0}}, !dos, p7ffd[4]};
		end
	end

endmodule

//--- hdl/zx_bus_out.sv
`timescale 1ns/100ps

module zx_bus_out import zx_pkg::*;
(
	input  logic [15:0]           a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic                  mreq_n,

	input  byte_t                 rd_data,
	input  logic                  port_unowned,
	input  logic [ROM_PAGE_W-1:0] rom_page,
	input  logic                  rom_sel,

	output byte_t                 d_out,
	output logic                  d_oe,
	output logic                  ay_bdir,
	output logic                  ay_bc1,
	output logic                  rompg0_n,
	output logic                  dos_n,
	output logic                  rompg2,
	output logic                  rompg3,
	output logic                  rompg4,
	output logic                  csrom
);

	port_sel_t port;
	logic      io_cyc;
	logic      io_rd;
	logic      reg_port;
	logic      ay_port;

	assign port = port_decode(a);

	// iorq with m1 low is an interrupt acknowledge, not a port access
	assign io_cyc = !iorq_n && m1_n;
	assign io_rd  = io_cyc && !rd_n;

	// AY ports are read by the chip itself
	assign reg_port = port inside {PORT_FE, PORT_7FFD, PORT_EFF7};
	assign ay_port  = (port == PORT_AY_REG) || (port == PORT_AY_DATA);

	////////////////////
	// data bus
	assign d_oe  = io_rd && (reg_port || port_unowned);
	assign d_out = reg_port ? rd_data : 8'hFF;

	// FFFD wr latches address, BFFD wr writes data, FFFD rd reads
	assign ay_bdir = io_cyc && !wr_n && ay_port;
	assign ay_bc1  = io_cyc && (port == PORT_AY_REG) && (!wr_n || !rd_n);

	////////////////////
	// ROM pins
	assign rompg0_n = !rom_page[0];
	assign dos_n    = rom_page[1];
	assign rompg2   = rom_page[2];
	assign rompg3   = rom_page[3];
	assign rompg4   = rom_page[4];
	assign csrom    = rom_sel && !mreq_n;

	always_comb
	begin
		a_no_drive_on_wr: assert final (!(d_oe && !wr_n))
			else $error("data bus driven while wr_n is low");
	end

endmodule

//--- hdl/zx_frame_timer.sv
`timescale 1ns/100ps

module zx_frame_timer
#(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN   = 32,
	parameter int AY_DIV_W  = 4
)
(
	input  logic fclk,
	input  logic rst_n,

	output logic int_n,
	output logic ay_clk
);

	localparam int FC_W = $clog2(FRAME_LEN);
	localparam int IC_W = $clog2(INT_LEN + 1);

	logic [FC_W-1:0]     frame_cnt;
	logic [IC_W-1:0]     int_cnt;
	logic [AY_DIV_W-1:0] ay_div;
	logic                frame_wrap;

	assign frame_wrap = (frame_cnt == FC_W'(FRAME_LEN - 1));

	////////////////////
	// frame counter and interrupt pulse
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			frame_cnt <= '0;
			int_cnt   <= '0;
			int_n     <= 1'b1;
		end
		else
		begin
			frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
			if (frame_wrap)
			begin
				int_n   <= 1'b0;
				int_cnt <= '0;
			end
			else if (!int_n)
			begin
				if (int_cnt == IC_W'(INT_LEN - 1))
					int_n <= 1'b1;
				else
					int_cnt <= int_cnt + 1'b1;
			end
		end
	end

	// free-running AY clock divider
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			ay_div <= '0;
		else
			ay_div <= ay_div + 1'b1;
	end

	assign ay_clk = ay_div[AY_DIV_W-1];

	a_int_width: assert property (@(posedge fclk) disable iff (!rst_n)
		$fell(int_n) |-> !int_n [*INT_LEN] ##1 int_n);

endmodule

//--- hdl/zx_glue_top.sv
`timescale 1ns/100ps

module zx_glue_top import zx_pkg::*;
#(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN   = 32,
	parameter int AY_DIV_W  = 4
)
(
	input  logic                  fclk,
	input  logic                  rst_n,

	// z80
	input  logic [15:0]           a,
	input  byte_t                 d_in,
	input  logic                  iorq_n,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic                  iorqge1,
	input  logic                  iorqge2,
	input  logic                  ear_in,

	output byte_t                 d_out,
	output logic                  d_oe,
	output logic                  int_n,

	// AY
	output logic                  ay_clk,
	output logic                  ay_bdir,
	output logic                  ay_bc1,

	// ROM
	output logic                  rompg0_n,
	output logic                  dos_n,
	output logic                  rompg2,
	output logic                  rompg3,
	output logic                  rompg4,
	output logic                  csrom,

	output logic [RAM_PAGE_W-1:0] ram_page,
	output logic                  rom_sel
);

	logic                  io_wr_stb;
	logic                  m1_stb;
	port_sel_t             wr_port;
	byte_t                 wr_data;
	byte_t                 m1_addr_hi;
	logic [2:0]            border;
	byte_t                 p7ffd;
	byte_t                 peff7;
	mem_mode_t             mem_mode;
	byte_t                 rd_data;
	logic                  port_unowned;
	logic [ROM_PAGE_W-1:0] rom_page;

	zx_bus_sync u_bus_sync (
		.fclk(fclk), .rst_n(rst_n), .a(a), .d_in(d_in),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.io_wr_stb(io_wr_stb), .m1_stb(m1_stb), .wr_port(wr_port),
		.wr_data(wr_data), .m1_addr_hi(m1_addr_hi)
	);

	zx_port_regs u_port_regs (
		.fclk(fclk), .rst_n(rst_n), .io_wr_stb(io_wr_stb), .wr_port(wr_port),
		.wr_data(wr_data), .a(a), .ear_in(ear_in), .iorqge1(iorqge1), .iorqge2(iorqge2),
		.border(border), .p7ffd(p7ffd), .peff7(peff7), .mem_mode(mem_mode),
		.rd_data(rd_data), .port_unowned(port_unowned)
	);

	zx_pager u_pager (
		.fclk(fclk), .rst_n(rst_n), .a(a[15:14]), .mreq_n(mreq_n),
		.m1_stb(m1_stb), .m1_addr_hi(m1_addr_hi),
		.p7ffd(p7ffd), .peff7(peff7), .mem_mode(mem_mode),
		.ram_page(ram_page), .rom_sel(rom_sel), .rom_page(rom_page)
	);

	zx_bus_out u_bus_out (
		.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .mreq_n(mreq_n),
		.rd_data(rd_data), .port_unowned(port_unowned),
		.rom_page(rom_page), .rom_sel(rom_sel),
		.d_out(d_out), .d_oe(d_oe), .ay_bdir(ay_bdir), .ay_bc1(ay_bc1),
		.rompg0_n(rompg0_n), .dos_n(dos_n), .rompg2(rompg2), .rompg3(rompg3),
		.rompg4(rompg4), .csrom(csrom)
	);

	zx_frame_timer #(
		.FRAME_LEN(FRAME_LEN),
		.INT_LEN(INT_LEN),
		.AY_DIV_W(AY_DIV_W)
	) u_frame_timer (
		.fclk(fclk), .rst_n(rst_n), .int_n(int_n), .ay_clk(ay_clk)
	);

endmodule

//--- verification/zx_checker.sv
`timescale 1ns/100ps

module zx_checker
#(
	parameter int FRAME_LEN = 2000,
	parameter int INT_LEN   = 16,
	parameter int AY_DIV_W  = 4
)
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        iorqge1,
	input  logic        iorqge2,
	input  logic        ear_in,
	input  logic [7:0]  d_out,
	input  logic        d_oe,
	input  logic        int_n,
	input  logic        ay_clk,
	input  logic        ay_bdir,
	input  logic        ay_bc1,
	input  logic        rompg0_n,
	input  logic        dos_n,
	input  logic [2:0]  rompg_hi,
	input  logic        csrom,
	input  logic [5:0]  ram_page,
	input  logic        rom_sel,
	output int          val_errs,
	output int          tim_errs,
	output int          int_pulses
);

	localparam int K_NONE = 0;
	localparam int K_FE   = 1;
	localparam int K_7FFD = 2;
	localparam int K_EFF7 = 3;
	localparam int K_AYR  = 4;
	localparam int K_AYD  = 5;

	// ay_clk half period in fclk cycles
	localparam int AY_HALF = 1 << (AY_DIV_W - 1);

	// model state
	logic [7:0]  m_7ffd;
	logic [7:0]  m_eff7;
	logic        m_dos;

	logic [15:0] last_a;
	logic [7:0]  last_d;
	logic        io_rd;
	logic        io_wr;
	logic        m1_rd;
	logic        io_wr_prev;
	logic        m1_prev;
	logic        int_prev;
	logic        seen_fall;
	logic        after_rst;
	logic        oe_exp;
	logic        ay_exp;
	int          kind;
	int          rd_cnt;
	int          mem_cnt;
	int          low_cnt;
	int          gap;
	int          ay_cyc;

	////////////////////
	// reference model
	function automatic int port_kind(input logic [15:0] addr);
		if (addr[0] == 1'b0)
			return K_FE;
		if (addr[15] == 1'b0 && addr[1] == 1'b0)
			return K_7FFD;
		if (addr == 16'hEFF7)
			return K_EFF7;
		if (addr == 16'hFFFD)
			return K_AYR;
		if (addr == 16'hBFFD)
			return K_AYD;
		return K_NONE;
	endfunction

	function automatic logic [7:0] ref_read(input int k, input logic ear);
		case (k)
			K_FE:    return {1'b1, ear, 6'h3F};
			K_7FFD:  return m_7ffd;
			K_EFF7:  return m_eff7;
			default: return 8'hFF;
		endcase
	endfunction

	// EFF7 bit 2 set means 128K paging
	function automatic logic [5:0] ref_page(input logic [1:0] win);
		case (win)
			2'd0:    return 6'd0;
			2'd1:    return 6'd5;
			2'd2:    return 6'd2;
			default: return m_eff7[2] ? {3'b000, m_7ffd[2:0]}
				: {m_7ffd[5], m_7ffd[7:6], m_7ffd[2:0]};
		endcase
	endfunction

	task automatic apply_write(input logic [15:0] addr, input logic [7:0] data);
		case (port_kind(addr))
			K_7FFD:
			begin
				if (!(m_eff7[2] && m_7ffd[5]))
					m_7ffd = data;
			end
			K_EFF7:
				m_eff7 = data;
			default:
			begin
			end
		endcase
	endtask

	task automatic apply_fetch(input logic [15:0] addr);
		if (addr[15:8] == 8'h3D && !m_eff7[3] && m_7ffd[4])
			m_dos = 1'b1;
		else if (addr >= 16'h4000)
			m_dos = 1'b0;
	endtask

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp)
		begin
			val_errs = val_errs + 1;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
		end
	endtask

	////////////////////
	// compare on the falling edge, away from both the DUT edge and the drive
	always @(negedge fclk)
	begin
		if (!rst_n)
		begin
			m_7ffd     = 8'h00;
			m_eff7     = 8'h00;
			m_dos      = 1'b0;
			io_wr_prev = 1'b0;
			m1_prev    = 1'b0;
			int_prev   = 1'b1;
			seen_fall  = 1'b0;
			after_rst  = 1'b1;
			rd_cnt     = 0;
			mem_cnt    = 0;
			low_cnt    = 0;
			gap        = 0;
			ay_cyc     = 0;
			val_errs   = 0;
			tim_errs   = 0;
			int_pulses = 0;
		end
		else
		begin
			if (after_rst)
			begin
				check_val("int_n", 8'h01, {7'd0, int_n});
				after_rst = 1'b0;
			end
			kind  = port_kind(a);
			io_rd = !iorq_n && m1_n && !rd_n;
			io_wr = !iorq_n && m1_n && !wr_n;
			m1_rd = !m1_n && !mreq_n && !rd_n;
			if (io_wr || m1_rd)
			begin
				last_a = a;
				last_d = d_in;
			end

			// pins that follow the raw bus
			oe_exp = io_rd && (kind == K_FE || kind == K_7FFD || kind == K_EFF7
				|| (kind == K_NONE && !iorqge1 && !iorqge2));
			check_val("d_oe", {7'd0, oe_exp}, {7'd0, d_oe});
			check_val("ay_bdir", {7'd0, io_wr && (kind == K_AYR || kind == K_AYD)},
				{7'd0, ay_bdir});
			check_val("ay_bc1", {7'd0, (io_wr || io_rd) && kind == K_AYR},
				{7'd0, ay_bc1});

			rd_cnt = io_rd ? rd_cnt + 1 : 0;
			if (rd_cnt == 4 && oe_exp)
				check_val("d_out", ref_read(kind, ear_in), d_out);

			// paging, settled well before the fourth cycle
			mem_cnt = !mreq_n ? mem_cnt + 1 : 0;
			if (mem_cnt == 4)
			begin
				check_val("ram_page", {2'b00, ref_page(a[15:14])}, {2'b00, ram_page});
				check_val("rom_sel", {7'd0, a[15:14] == 2'd0 && !m_eff7[3]},
					{7'd0, rom_sel});
				check_val("csrom", {7'd0, a[15:14] == 2'd0 && !m_eff7[3]},
					{7'd0, csrom});
			end
			// ROM chip select only inside a memory cycle
			if (mreq_n)
				check_val("csrom", 8'h00, {7'd0, csrom});

			if (io_wr_prev && !io_wr)
				apply_write(last_a, last_d);
			if (m1_prev && !m1_rd)
				apply_fetch(last_a);
			if ((io_wr_prev && !io_wr) || (m1_prev && !m1_rd))
			begin
				check_val("rompg0_n", {7'd0, !m_7ffd[4]}, {7'd0, rompg0_n});
				check_val("dos_n", {7'd0, !m_dos}, {7'd0, dos_n});
				check_val("rompg_hi", 8'h00, {5'd0, rompg_hi});
			end
			io_wr_prev = io_wr;
			m1_prev    = m1_rd;

			////////////////////
			// frame interrupt timing
			gap = gap + 1;
			if (int_prev && !int_n)
			begin
				if (seen_fall && gap != FRAME_LEN)
				begin
					tim_errs = tim_errs + 1;
					$display("int_n pulses came %0d cycles apart instead of %0d at %0t",
						gap, FRAME_LEN, $time);
				end
				seen_fall  = 1'b1;
				gap        = 0;
				int_pulses = int_pulses + 1;
			end
			if (!int_n)
				low_cnt = low_cnt + 1;
			else if (low_cnt != 0)
			begin
				if (low_cnt != INT_LEN)
				begin
					tim_errs = tim_errs + 1;
					$display("int_n stayed low for %0d cycles instead of %0d at %0t",
						low_cnt, INT_LEN, $time);
				end
				low_cnt = 0;
			end
			int_prev = int_n;

			////////////////////
			// AY clock, low for the first half period after reset
			ay_exp = ((ay_cyc / AY_HALF) % 2) == 1;
			check_val("ay_clk", {7'd0, ay_exp}, {7'd0, ay_clk});
			ay_cyc = (ay_cyc + 1) % (2 * AY_HALF);
		end
	end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/100ps

module tb_top;

	localparam int FRAME_LEN = 2000;
	localparam int INT_LEN   = 16;
	localparam int AY_DIV_W  = 4;
	localparam int HOLD      = 6;
	localparam int IDLE      = 2;
	localparam int N_PAGE    = 12;
	localparam int N_PORT    = 16;

	// one bus op is a start edge, the hold and the idle gap
	localparam int OP_CYC    = 1 + HOLD + IDLE;
	localparam int N_OPS     = 3 * N_PAGE * 5 + 2 * N_PORT + 20;
	// twice the expected run, with a spare frame
	localparam int CYC_LIMIT = 2 * (N_OPS * OP_CYC + 4 * FRAME_LEN);

	logic        fclk = 1'b0;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic        iorqge1;
	logic        iorqge2;
	logic        ear_in;
	logic [7:0]  d_out;
	logic        d_oe;
	logic        int_n;
	logic        ay_clk;
	logic        ay_bdir;
	logic        ay_bc1;
	logic        rompg0_n;
	logic        dos_n;
	logic        rompg2;
	logic        rompg3;
	logic        rompg4;
	logic        csrom;
	logic [5:0]  ram_page;
	logic        rom_sel;

	int          val_errs;
	int          tim_errs;
	int          int_pulses;
	int          cyc_cnt = 0;
	logic [31:0] lfsr_state;

	always #5 fclk = ~fclk;

	zx_glue_top #(
		.FRAME_LEN(FRAME_LEN),
		.INT_LEN(INT_LEN),
		.AY_DIV_W(AY_DIV_W)
	) DUT (.*);

	zx_checker #(
		.FRAME_LEN(FRAME_LEN),
		.INT_LEN(INT_LEN),
		.AY_DIV_W(AY_DIV_W)
	) chk (
		.fclk(fclk), .rst_n(rst_n), .a(a), .d_in(d_in),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.iorqge1(iorqge1), .iorqge2(iorqge2), .ear_in(ear_in),
		.d_out(d_out), .d_oe(d_oe), .int_n(int_n), .ay_clk(ay_clk),
		.ay_bdir(ay_bdir), .ay_bc1(ay_bc1),
		.rompg0_n(rompg0_n), .dos_n(dos_n), .rompg_hi({rompg4, rompg3, rompg2}),
		.csrom(csrom), .ram_page(ram_page), .rom_sel(rom_sel),
		.val_errs(val_errs), .tim_errs(tim_errs), .int_pulses(int_pulses)
	);

	always @(posedge fclk)
		cyc_cnt <= cyc_cnt + 1;

	////////////////////
	// galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		else
			return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	////////////////////
	// Z80 bus cycles
	task automatic end_cycle();
		repeat (HOLD) @(posedge fclk);
		#1;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (IDLE) @(posedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge fclk);
		#1;
		a      = addr;
		d_in   = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		end_cycle();
	endtask

	task automatic io_read(input logic [15:0] addr);
		@(posedge fclk);
		#1;
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		end_cycle();
	endtask

	task automatic mem_read(input logic [15:0] addr);
		@(posedge fclk);
		#1;
		a      = addr;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		end_cycle();
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		@(posedge fclk);
		#1;
		a      = addr;
		m1_n   = 1'b0;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		end_cycle();
	endtask

	// external claim lines and the tape input
	task automatic set_ext(input logic ge1, input logic ge2, input logic ear);
		@(posedge fclk);
		#1;
		iorqge1 = ge1;
		iorqge2 = ge2;
		ear_in  = ear;
	endtask

	////////////////////
	// test groups
	task automatic run_paging(input logic mode);
		logic [15:0] r;
		logic [15:0] adr;
		int i;
		for (i = 0; i < N_PAGE; i++)
		begin
			rand_bits(8, r);
			io_write(16'hEFF7, {r[7:3], mode, r[1:0]});
			// 7FFD partial decode, any A14..A2
			rand_bits(13, adr);
			rand_bits(8, r);
			io_write({1'b0, adr[12:0], 2'b01}, r[7:0]);
			io_read(16'h7FFD);
			io_read(16'hEFF7);
			rand_bits(14, adr);
			mem_read({2'b11, adr[13:0]});
		end
	endtask

	task automatic run_port_reads();
		logic [15:0] r;
		logic [15:0] adr;
		int i;
		for (i = 0; i < N_PORT; i++)
		begin
			rand_bits(16, adr);
			rand_bits(3, r);
			set_ext(r[0] && r[1], r[0] && r[2], r[1]);
			io_read(adr);
		end
		set_ext(1'b0, 1'b0, 1'b1);
		io_read(16'h00FE);
		io_read(16'h12F7);
		set_ext(1'b1, 1'b0, 1'b0);
		io_read(16'h12F7);
		set_ext(1'b0, 1'b1, 1'b0);
		io_read(16'hFF3B);
		set_ext(1'b0, 1'b0, 1'b0);
		io_read(16'h7FFE);
	endtask

	task automatic run_ay();
		io_write(16'hFFFD, 8'h07);
		io_write(16'hBFFD, 8'h3F);
		io_read(16'hFFFD);
		io_read(16'hBFFD);
	endtask

	task automatic run_dos();
		io_write(16'hEFF7, 8'h00);
		io_write(16'h7FFD, 8'h00);
		// 128 ROM paged, no DOS entry
		m1_fetch(16'h3D2F);
		io_write(16'h7FFD, 8'h10);
		m1_fetch(16'h3D2F);
		mem_read(16'h0100);
		m1_fetch(16'h1234);
		m1_fetch(16'h8000);
		io_write(16'hEFF7, 8'h08);
		mem_read(16'h0100);
		m1_fetch(16'h3D00);
		io_write(16'hEFF7, 8'h00);
	endtask

	task automatic end_run(input logic timed_out);
		$display("error count: %0d value, %0d timing, %0d timeout",
			val_errs, tim_errs, timed_out);
		if (!timed_out && val_errs == 0 && tim_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	initial
	begin
		rst_n      = 1'b0;
		a          = 16'h0000;
		d_in       = 8'h00;
		iorq_n     = 1'b1;
		mreq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		iorqge1    = 1'b0;
		iorqge2    = 1'b0;
		ear_in     = 1'b0;
		lfsr_state = 32'hfe0d;
		repeat (10) @(posedge fclk);
		#1;
		rst_n = 1'b1;

		mem_read(16'hC000);
		run_paging(1'b0);
		run_paging(1'b1);
		run_paging(1'b0);
		run_port_reads();
		run_ay();
		run_dos();

		// three interrupts give two full frame intervals
		wait (int_pulses >= 3);
		wait (int_n);
		repeat (2) @(posedge fclk);
		end_run(1'b0);
	end

	initial
	begin
		wait (cyc_cnt >= CYC_LIMIT);
		$display("timeout: run still going after %0d cycles", CYC_LIMIT);
		end_run(1'b1);
	end

endmodule

//--- sources.f
hdl/zx_pkg.sv
hdl/zx_bus_sync.sv
hdl/zx_port_regs.sv
hdl/zx_pager.sv
hdl/zx_bus_out.sv
hdl/zx_frame_timer.sv
hdl/zx_glue_top.sv
verification/zx_checker.sv
verification/tb_top.sv
